/* src/mips_cfg.svh */
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

////////////////////////////////////////
// Widths and sizes
////////////////////////////////////////
`define MIPS_WORD_W     32
`define MIPS_REG_W      5
`define MIPS_NUM_REGS   32
`define RESET_PC        32'h0000_0000       // First fetch address

////////////////////////////////////////
// Opcodes, instr[31:26]
////////////////////////////////////////
`define OP_RTYPE        6'h00
`define OP_J            6'h02
`define OP_BEQ          6'h04
`define OP_ADDI         6'h08
`define OP_LW           6'h23
`define OP_SW           6'h2b

// Funct field of R-type, instr[5:0]
`define FN_ADD          6'h20
`define FN_SUB          6'h22
`define FN_AND          6'h24
`define FN_OR           6'h25
`define FN_SLT          6'h2a

// ALU operation codes
`define ALU_AND         3'd0
`define ALU_OR          3'd1
`define ALU_ADD         3'd2
`define ALU_SUB         3'd6
`define ALU_SLT         3'd7

// Forward selects, 2'b11 never used
`define FWD_NONE        2'b00               // Register file value
`define FWD_WB          2'b01               // Writeback result
`define FWD_MEM         2'b10               // Memory stage alu_out

`endif

/* src/mips_pkg.sv */
`default_nettype none
`include "mips_cfg.svh"

package mips_pkg;

    ////////////////////////////////////////
    // Shared vector types
    ////////////////////////////////////////

    // Data or address word
    typedef logic [`MIPS_WORD_W-1:0] word_t;

    // Register number, rs / rt / rd fields
    typedef logic [`MIPS_REG_W-1:0] reg_addr_t;

    // ALU operation, see ALU_* codes
    typedef logic [2:0] alu_op_t;

    // Operand source in execute, see FWD_* codes
    typedef logic [1:0] fwd_sel_t;

endpackage

`default_nettype wire

/* src/pipe_ifs.sv */
`default_nettype none

// Decode to execute pipeline register contents
interface de_if;
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    mips_pkg::reg_addr_t rd;
    mips_pkg::word_t     rd0;           // Register value of rs
    mips_pkg::word_t     rd1;           // Register value of rt
    mips_pkg::word_t     imm;           // Sign extended
    mips_pkg::alu_op_t   alu_op;
    logic                alu_src_imm;   // ALU B from imm
    logic                reg_dst;       // Write rd, else rt
    logic                rf_we;
    logic                mem_to_reg;
    logic                dmem_we;

    modport decode  (output rs, rt, rd, rd0, rd1, imm, alu_op, alu_src_imm, reg_dst,
                     rf_we, mem_to_reg, dmem_we);
    modport execute (input  rs, rt, rd, rd0, rd1, imm, alu_op, alu_src_imm, reg_dst,
                     rf_we, mem_to_reg, dmem_we);
endinterface

// Execute to memory pipeline register contents
interface em_if;
    mips_pkg::word_t     alu_out;       // Result or memory address
    mips_pkg::word_t     store_data;
    mips_pkg::reg_addr_t rf_wa;
    logic                rf_we;
    logic                mem_to_reg;
    logic                dmem_we;

    modport execute (output alu_out, store_data, rf_wa, rf_we, mem_to_reg, dmem_we);
    modport memory  (input  alu_out, store_data, rf_wa, rf_we, mem_to_reg, dmem_we);
    modport hazard  (input  rf_wa, rf_we);
endinterface

// Hazard detection, carries clock for the unit's checks
interface hz_if (input logic clock, input logic rst_n);
    mips_pkg::reg_addr_t d_rs;
    mips_pkg::reg_addr_t d_rt;
    mips_pkg::reg_addr_t e_rs;
    mips_pkg::reg_addr_t e_rt;
    logic                e_mem_to_reg;  // LW in execute
    logic                stall;         // Hold PC and F/D
    logic                flush;         // Bubble into D/E
    mips_pkg::fwd_sel_t  fwd_a;
    mips_pkg::fwd_sel_t  fwd_b;

    modport hazard  (input  clock, rst_n, d_rs, d_rt, e_rs, e_rt, e_mem_to_reg,
                     output stall, flush, fwd_a, fwd_b);
    modport decode  (output d_rs, d_rt, input flush);
    modport execute (output e_rs, e_rt, e_mem_to_reg, input fwd_a, fwd_b);
endinterface

`default_nettype wire

/* src/fetch_stage.sv */
`default_nettype none
`include "mips_cfg.svh"

module fetch_stage (
    input  logic            clock,
    input  logic            rst_n,
    input  mips_pkg::word_t instruction,    // From instruction memory, same cycle
    input  logic            stall,
    input  logic            branch_taken,   // BEQ resolved in decode
    input  mips_pkg::word_t branch_target,
    output mips_pkg::word_t pc,
    output mips_pkg::word_t f_instr,        // F/D register
    output mips_pkg::word_t f_pc_plus4
);

    mips_pkg::word_t pc_plus4;
    mips_pkg::word_t jump_addr;
    mips_pkg::word_t pc_next;
    logic            is_jump;

    assign pc_plus4 = pc + 32'd4;

    // J caught before decode, so no slot follows it
    assign is_jump   = (instruction[31:26] == `OP_J);
    assign jump_addr = {pc_plus4[31:28], instruction[25:0], 2'b00};

    // Jump wins over branch, branch over sequential
    always_comb begin
        if (is_jump)
            pc_next = jump_addr;
        else if (branch_taken)
            pc_next = branch_target;
        else
            pc_next = pc_plus4;
    end

    ////////////////////////////////////////
    // PC and F/D register
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            pc         <= `RESET_PC;
            f_instr    <= '0;               // SLL $0 no-op
            f_pc_plus4 <= '0;
        end else if (!stall) begin          // Load-use holds both
            pc         <= pc_next;
            f_instr    <= instruction;
            f_pc_plus4 <= pc_plus4;
        end
    end

endmodule

`default_nettype wire

/* src/decode_stage.sv */
`default_nettype none
`include "mips_cfg.svh"

module decode_stage (
    input  logic                clock,
    input  logic                rst_n,
    input  mips_pkg::word_t     f_instr,
    input  mips_pkg::word_t     f_pc_plus4,
    input  logic                wb_we,          // Writeback port
    input  mips_pkg::reg_addr_t wb_wa,
    input  mips_pkg::word_t     wb_data,
    input  mips_pkg::reg_addr_t dbg_ra,         // Observation port
    output mips_pkg::word_t     dbg_rd,
    output logic                branch_taken,
    output mips_pkg::word_t     branch_target,
    de_if.decode                de,
    hz_if.decode                hz
);

    mips_pkg::word_t     regs [`MIPS_NUM_REGS];
    logic [5:0]          opcode;
    logic [5:0]          funct;
    mips_pkg::reg_addr_t rs;
    mips_pkg::reg_addr_t rt;
    mips_pkg::reg_addr_t rd;
    mips_pkg::word_t     imm;
    mips_pkg::word_t     rd0;
    mips_pkg::word_t     rd1;
    mips_pkg::alu_op_t   alu_op;
    logic                alu_src_imm;
    logic                reg_dst;
    logic                rf_we;
    logic                mem_to_reg;
    logic                dmem_we;
    logic                is_beq;

    // Instruction fields
    assign opcode = f_instr[31:26];
    assign rs     = f_instr[25:21];
    assign rt     = f_instr[20:16];
    assign rd     = f_instr[15:11];
    assign funct  = f_instr[5:0];
    assign imm    = {{16{f_instr[15]}}, f_instr[15:0]};

    assign hz.d_rs = rs;                        // Load-use check
    assign hz.d_rt = rt;

    ////////////////////////////////////////
    // Control decode
    ////////////////////////////////////////
    always_comb begin
        alu_op      = `ALU_ADD;                 // Also the address adder
        alu_src_imm = 1'b0;
        reg_dst     = 1'b0;
        rf_we       = 1'b0;
        mem_to_reg  = 1'b0;
        dmem_we     = 1'b0;
        is_beq      = 1'b0;
        case (opcode)
            `OP_RTYPE: begin
                reg_dst = 1'b1;
                rf_we   = 1'b1;
                case (funct)
                    `FN_ADD: alu_op = `ALU_ADD;
                    `FN_SUB: alu_op = `ALU_SUB;
                    `FN_AND: alu_op = `ALU_AND;
                    `FN_OR:  alu_op = `ALU_OR;
                    `FN_SLT: alu_op = `ALU_SLT;
                    default: rf_we  = 1'b0;     // SLL and others as no-op
                endcase
            end
            `OP_ADDI: begin
                alu_src_imm = 1'b1;
                rf_we       = 1'b1;
            end
            `OP_LW: begin
                alu_src_imm = 1'b1;
                rf_we       = 1'b1;
                mem_to_reg  = 1'b1;
            end
            `OP_SW: begin
                alu_src_imm = 1'b1;
                dmem_we     = 1'b1;
            end
            `OP_BEQ: is_beq = 1'b1;
            default: ;                          // J already taken in fetch
        endcase
    end

    ////////////////////////////////////////
    // Register file
    ////////////////////////////////////////

    // $0 reads zero, a same-cycle write passes through
    function automatic mips_pkg::word_t rf_read(input mips_pkg::reg_addr_t ra);
        if (ra == '0)
            return '0;
        if (wb_we && (wb_wa == ra))
            return wb_data;
        return regs[ra];
    endfunction

    always_ff @(posedge clock) begin
        if (wb_we && (wb_wa != '0))
            regs[wb_wa] <= wb_data;
    end

    always_comb begin
        rd0    = rf_read(rs);
        rd1    = rf_read(rt);
        dbg_rd = rf_read(dbg_ra);
    end

    // BEQ on raw register values, nothing forwarded
    assign branch_taken  = is_beq && (rd0 == rd1);
    assign branch_target = f_pc_plus4 + {imm[29:0], 2'b00};

    ////////////////////////////////////////
    // D/E register
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (!rst_n || hz.flush) begin           // Bubble, nothing written
            de.alu_op      <= '0;
            de.alu_src_imm <= 1'b0;
            de.reg_dst     <= 1'b0;
            de.rf_we       <= 1'b0;
            de.mem_to_reg  <= 1'b0;
            de.dmem_we     <= 1'b0;
        end else begin
            de.alu_op      <= alu_op;
            de.alu_src_imm <= alu_src_imm;
            de.reg_dst     <= reg_dst;
            de.rf_we       <= rf_we;
            de.mem_to_reg  <= mem_to_reg;
            de.dmem_we     <= dmem_we;
        end
        de.rs  <= rs;
        de.rt  <= rt;
        de.rd  <= rd;
        de.rd0 <= rd0;
        de.rd1 <= rd1;
        de.imm <= imm;
    end

    // A taken branch is a BEQ, and it moves on without any write
    a_branch_is_beq: assert property (@(posedge clock) disable iff (!rst_n)
        branch_taken |-> (opcode == `OP_BEQ) ##1 (!de.rf_we && !de.dmem_we));

endmodule

`default_nettype wire

/* src/execute_stage.sv */
`default_nettype none
`include "mips_cfg.svh"

module execute_stage (
    input  logic            clock,
    input  logic            rst_n,
    de_if.execute           de,
    input  mips_pkg::word_t wb_data,        // Writeback result for forwarding
    em_if.execute           em,
    hz_if.execute           hz
);

    mips_pkg::word_t     src_a;
    mips_pkg::word_t     src_b;             // Forwarded rt, also store data
    mips_pkg::word_t     alu_b;
    mips_pkg::word_t     alu_y;
    mips_pkg::reg_addr_t wa;

    assign hz.e_rs         = de.rs;
    assign hz.e_rt         = de.rt;
    assign hz.e_mem_to_reg = de.mem_to_reg;

    ////////////////////////////////////////
    // Operand forwarding
    ////////////////////////////////////////
    function automatic mips_pkg::word_t fwd_mux(
        input mips_pkg::fwd_sel_t sel,
        input mips_pkg::word_t    reg_val,
        input mips_pkg::word_t    mem_val,
        input mips_pkg::word_t    wb_val
    );
        case (sel)
            `FWD_MEM: return mem_val;
            `FWD_WB:  return wb_val;
            default:  return reg_val;
        endcase
    endfunction

    assign src_a = fwd_mux(hz.fwd_a, de.rd0, em.alu_out, wb_data);
    assign src_b = fwd_mux(hz.fwd_b, de.rd1, em.alu_out, wb_data);
    assign alu_b = de.alu_src_imm ? de.imm : src_b;

    // ALU
    always_comb begin
        case (de.alu_op)
            `ALU_ADD: alu_y = src_a + alu_b;
            `ALU_SUB: alu_y = src_a - alu_b;
            `ALU_AND: alu_y = src_a & alu_b;
            `ALU_OR:  alu_y = src_a | alu_b;
            `ALU_SLT: alu_y = {31'd0, $signed(src_a) < $signed(alu_b)};   // Signed compare
            default:  alu_y = '0;
        endcase
    end

    assign wa = de.reg_dst ? de.rd : de.rt;    // rd for R-type

    ////////////////////////////////////////
    // E/M register
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            em.rf_we      <= 1'b0;
            em.mem_to_reg <= 1'b0;
            em.dmem_we    <= 1'b0;
        end else begin
            em.rf_we      <= de.rf_we;
            em.mem_to_reg <= de.mem_to_reg;
            em.dmem_we    <= de.dmem_we;
        end
        em.alu_out    <= alu_y;
        em.store_data <= src_b;
        em.rf_wa      <= wa;
    end

    // Hazard unit never produces the spare select code
    a_fwd_legal: assert property (@(posedge clock) disable iff (!rst_n)
        (hz.fwd_a inside {`FWD_NONE, `FWD_WB, `FWD_MEM}) &&
        (hz.fwd_b inside {`FWD_NONE, `FWD_WB, `FWD_MEM}));

endmodule

`default_nettype wire

/* src/mem_wb_stage.sv */
`default_nettype none

module mem_wb_stage (
    input  logic                clock,
    input  logic                rst_n,
    em_if.memory                em,
    output mips_pkg::word_t     dmem_addr,
    output mips_pkg::word_t     dmem_wd,
    output logic                dmem_we,
    input  mips_pkg::word_t     dmem_rd,    // Combinational read data
    output logic                wb_we,
    output mips_pkg::reg_addr_t wb_wa,
    output mips_pkg::word_t     wb_data
);

    mips_pkg::word_t w_load;
    mips_pkg::word_t w_alu_out;
    logic            w_mem_to_reg;

    // Data memory port, write lands at next edge
    assign dmem_addr = em.alu_out;
    assign dmem_wd   = em.store_data;
    assign dmem_we   = em.dmem_we;

    ////////////////////////////////////////
    // M/W register
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            wb_we        <= 1'b0;
            w_mem_to_reg <= 1'b0;
        end else begin
            wb_we        <= em.rf_we;
            w_mem_to_reg <= em.mem_to_reg;
        end
        wb_wa     <= em.rf_wa;
        w_load    <= dmem_rd;
        w_alu_out <= em.alu_out;
    end

    // Result back to register file and forward path
    assign wb_data = w_mem_to_reg ? w_load : w_alu_out;

    // Decode never marks an instruction as both store and load
    a_store_not_load: assert property (@(posedge clock) disable iff (!rst_n)
        !(dmem_we && em.mem_to_reg));

endmodule

`default_nettype wire

/* src/hazard_unit.sv */
`default_nettype none
`include "mips_cfg.svh"

module hazard_unit (
    hz_if.hazard                hz,
    em_if.hazard                em,
    input  logic                wb_we,
    input  mips_pkg::reg_addr_t wb_wa
);

    ////////////////////////////////////////
    // Forwarding selects
    ////////////////////////////////////////

    // Youngest producer first, $0 never forwarded
    function automatic mips_pkg::fwd_sel_t pick_fwd(input mips_pkg::reg_addr_t ra);
        if (em.rf_we && (em.rf_wa != '0) && (em.rf_wa == ra))
            return `FWD_MEM;
        if (wb_we && (wb_wa != '0) && (wb_wa == ra))
            return `FWD_WB;
        return `FWD_NONE;
    endfunction

    always_comb begin
        hz.fwd_a = pick_fwd(hz.e_rs);
        hz.fwd_b = pick_fwd(hz.e_rt);       // Also covers store data
    end

    ////////////////////////////////////////
    // Load-use stall
    ////////////////////////////////////////

    // LW result not ready until writeback, so hold one cycle
    always_comb begin
        hz.stall = hz.e_mem_to_reg &&
                   ((hz.e_rt == hz.d_rs) || (hz.e_rt == hz.d_rt));
        hz.flush = hz.stall;                // Bubble fills the gap
    end

    // Flush comes with stall, and the bubble ends it after one cycle
    a_stall_one_cycle: assert property (@(posedge hz.clock) disable iff (!hz.rst_n)
        hz.flush |-> hz.stall ##1 !hz.stall);

endmodule

`default_nettype wire

/* src/mips_pipeline.sv */
`default_nettype none

module mips_pipeline (
    input  logic                clock,
    input  logic                rst_n,
    input  mips_pkg::word_t     instruction,    // Instruction memory
    output mips_pkg::word_t     pc,
    output mips_pkg::word_t     dmem_addr,      // Data memory
    output mips_pkg::word_t     dmem_wd,
    output logic                dmem_we,
    input  mips_pkg::word_t     dmem_rd,
    input  mips_pkg::reg_addr_t dbg_ra,         // Register observation
    output mips_pkg::word_t     dbg_rd
);

    ////////////////////////////////////////
    // Stage links
    ////////////////////////////////////////
    de_if de_bus ();
    em_if em_bus ();
    hz_if hz_bus (.clock(clock), .rst_n(rst_n));

    mips_pkg::word_t     f_instr;
    mips_pkg::word_t     f_pc_plus4;
    logic                branch_taken;
    mips_pkg::word_t     branch_target;
    logic                wb_we;                 // Writeback, back to decode
    mips_pkg::reg_addr_t wb_wa;
    mips_pkg::word_t     wb_data;

    ////////////////////////////////////////
    // Stages
    ////////////////////////////////////////
    fetch_stage fetch_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .instruction   (instruction),
        .stall         (hz_bus.stall),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .pc            (pc),
        .f_instr       (f_instr),
        .f_pc_plus4    (f_pc_plus4)
    );

    decode_stage decode_i (
        .clock         (clock),
        .rst_n         (rst_n),
        .f_instr       (f_instr),
        .f_pc_plus4    (f_pc_plus4),
        .wb_we         (wb_we),
        .wb_wa         (wb_wa),
        .wb_data       (wb_data),
        .dbg_ra        (dbg_ra),
        .dbg_rd        (dbg_rd),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .de            (de_bus.decode),
        .hz            (hz_bus.decode)
    );

    execute_stage execute_i (
        .clock   (clock),
        .rst_n   (rst_n),
        .de      (de_bus.execute),
        .wb_data (wb_data),
        .em      (em_bus.execute),
        .hz      (hz_bus.execute)
    );

    mem_wb_stage mem_wb_i (
        .clock     (clock),
        .rst_n     (rst_n),
        .em        (em_bus.memory),
        .dmem_addr (dmem_addr),
        .dmem_wd   (dmem_wd),
        .dmem_we   (dmem_we),
        .dmem_rd   (dmem_rd),
        .wb_we     (wb_we),
        .wb_wa     (wb_wa),
        .wb_data   (wb_data)
    );

    hazard_unit hazard_i (
        .hz    (hz_bus.hazard),
        .em    (em_bus.hazard),
        .wb_we (wb_we),
        .wb_wa (wb_wa)
    );

endmodule

`default_nettype wire

/* bench/tb_mem_models.sv */
`default_nettype none

// Instruction ROM, read in the same cycle as pc
module instr_rom (
    input  mips_pkg::word_t addr,
    output mips_pkg::word_t data
);
    mips_pkg::word_t mem [256];             // Loaded by the testbench

    initial begin
        for (int i = 0; i < 256; i++)
            mem[i] = '0;                    // SLL $0 no-op
    end

    assign data = mem[addr[9:2]];
endmodule

// Data RAM, clocked write and combinational read
module data_ram (
    input  logic            clock,
    input  mips_pkg::word_t addr,
    input  mips_pkg::word_t wd,
    input  logic            we,
    output mips_pkg::word_t rd
);
    mips_pkg::word_t mem [256];

    initial begin
        for (int i = 0; i < 256; i++)
            mem[i] = {i[7:0], ~i[7:0], i[7:0], ~i[7:0]};   // Per address
    end

    always @(posedge clock) begin
        if (we)
            mem[addr[9:2]] <= wd;
    end

    assign rd = mem[addr[9:2]];
endmodule

`default_nettype wire

/* bench/mips_pipeline_tb.sv */
`default_nettype none
`include "mips_cfg.svh"

module mips_pipeline_tb;
    logic                clock;
    logic                rst_n;
    logic                dmem_we;
    mips_pkg::word_t     instruction, pc, dmem_addr, dmem_wd, dmem_rd, dbg_rd;
    mips_pkg::reg_addr_t dbg_ra;
    integer              seed;
    int                  errors, checks, tests;
    logic                timed_out;
    mips_pkg::word_t     prog [$];
    mips_pkg::word_t     exp_regs [32];
    mips_pkg::word_t     st_addr [$];        // Expected stores, in order
    mips_pkg::word_t     st_data [$];
    mips_pkg::word_t     end_addr;

    mips_pipeline mips_pipeline_i (.clock(clock), .rst_n(rst_n), .instruction(instruction),
        .pc(pc), .dmem_addr(dmem_addr), .dmem_wd(dmem_wd), .dmem_we(dmem_we),
        .dmem_rd(dmem_rd), .dbg_ra(dbg_ra), .dbg_rd(dbg_rd));
    instr_rom rom_i (.addr(pc), .data(instruction));
    data_ram  ram_i (.clock(clock), .addr(dmem_addr), .wd(dmem_wd), .we(dmem_we), .rd(dmem_rd));

    initial clock = 1'b0;
    always #20 clock = ~clock;

    // Reset state, also one cycle past release
    a_reset_state: assert property (@(posedge clock) !rst_n |=> (pc == `RESET_PC) && !dmem_we)
        else begin
            $display("MISMATCH %0t pc/dmem_we exp %h/0 got %h/%b", $time, `RESET_PC, pc, dmem_we);
            errors++;
        end

    ////////////////////////////////////////
    // Store order check
    ////////////////////////////////////////
    always @(negedge clock) begin
        if (rst_n && dmem_we) begin
            checks++;
            if (st_addr.size() == 0) begin
                $display("Store at %0t to %h that the program never makes", $time, dmem_addr);
                errors++;
            end else begin
                a_st_addr: assert (dmem_addr == st_addr[0]) else begin
                    $display("MISMATCH %0t dmem_addr exp %h got %h", $time, st_addr[0], dmem_addr);
                    errors++;
                end
                a_st_data: assert (dmem_wd == st_data[0]) else begin
                    $display("MISMATCH %0t dmem_wd exp %h got %h", $time, st_data[0], dmem_wd);
                    errors++;
                end
                void'(st_addr.pop_front());
                void'(st_data.pop_front());
            end
        end
    end

    // Instruction encoders
    function automatic mips_pkg::word_t r_type(int fn, int rd, int rs, int rt);
        return {`OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn[5:0]};
    endfunction

    function automatic mips_pkg::word_t i_type(logic [5:0] op, int rt, int rs, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic mips_pkg::word_t j_type(mips_pkg::word_t target);
        return {`OP_J, target[27:2]};
    endfunction

    function automatic int rnd(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic start_program();
        prog.delete();
        for (int r = 1; r < 32; r++)
            prog.push_back(i_type(`OP_ADDI, r, 0, $random(seed)));   // Every register defined
    endtask

    ////////////////////////////////////////
    // Reference model, instruction level
    ////////////////////////////////////////
    task automatic run_model();
        mips_pkg::word_t mr [32];
        mips_pkg::word_t mm [256];          // Own copy of the data RAM
        mips_pkg::word_t ins, a, b, simm, res, p, nxt, pend_pc;
        logic            pend, taken;
        int              steps;
        repeat (5) prog.push_back('0);      // Drain pads
        end_addr = prog.size() * 4;
        for (int i = 0; i < 256; i++) begin
            mm[i] = $random(seed);
            ram_i.mem[i] = mm[i];
        end
        for (int i = 0; i < 32; i++)
            mr[i] = '0;
        p = `RESET_PC;
        pend = 1'b0;
        steps = 0;
        while (p < end_addr && steps < 1000) begin
            ins  = prog[p >> 2];
            a    = mr[ins[25:21]];
            b    = mr[ins[20:16]];
            simm = {{16{ins[15]}}, ins[15:0]};
            nxt  = p + 4;
            taken = 1'b0;
            case (ins[31:26])
                `OP_RTYPE: begin
                    case (ins[5:0])
                        `FN_ADD: res = a + b;
                        `FN_SUB: res = a - b;
                        `FN_AND: res = a & b;
                        `FN_OR:  res = a | b;
                        `FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default: res = mr[ins[15:11]];
                    endcase
                    if (ins[15:11] != 0) mr[ins[15:11]] = res;
                end
                `OP_ADDI: if (ins[20:16] != 0) mr[ins[20:16]] = a + simm;
                `OP_LW:   if (ins[20:16] != 0) mr[ins[20:16]] = mm[((a + simm) >> 2) & 255];
                `OP_SW: begin
                    mm[((a + simm) >> 2) & 255] = b;
                    st_addr.push_back(a + simm);
                    st_data.push_back(b);
                end
                `OP_BEQ: taken = (a == b);
                `OP_J:   nxt = {nxt[31:28], ins[25:0], 2'b00};
                default: ;
            endcase
            if (pend) begin
                p = pend_pc;                // Delay slot done
                pend = 1'b0;
            end else
                p = nxt;
            if (taken) begin
                pend = 1'b1;
                pend_pc = nxt + (simm << 2);
            end
            steps++;
        end
        for (int i = 0; i < 32; i++)
            exp_regs[i] = mr[i];
    endtask

    task automatic reset_dut();
        @(posedge clock);
        #5 rst_n = 1'b0;
        repeat (16) @(posedge clock);
        #5 rst_n = 1'b1;
    endtask

    ////////////////////////////////////////
    // One program from reset to sweep
    ////////////////////////////////////////
    task automatic run_test(string name);
        int err0, cyc;
        err0 = errors;
        for (int i = 0; i < 256; i++)
            rom_i.mem[i] = '0;
        run_model();
        for (int i = 0; i < prog.size(); i++)
            rom_i.mem[i] = prog[i];
        reset_dut();
        cyc = 0;
        while (pc < end_addr && !timed_out) begin
            @(negedge clock);
            cyc++;
            if (cyc > 2000) begin
                $display("TIMEOUT: pc never reached %h in test %s", end_addr, name);
                timed_out = 1'b1;
            end
        end
        for (int r = 0; r < 32 && !timed_out; r++) begin
            @(posedge clock);
            #5 dbg_ra = r[4:0];
            @(negedge clock);
            checks++;
            a_reg: assert (dbg_rd === exp_regs[r]) else begin
                $display("MISMATCH %0t dbg_rd[%0d] exp %h got %h", $time, r, exp_regs[r], dbg_rd);
                errors++;
            end
        end
        if (st_addr.size() != 0 && !timed_out) begin
            $display("Test %s ended with %0d expected stores never made", name, st_addr.size());
            errors++;
        end
        st_addr.delete();
        st_data.delete();
        tests++;
        $display("test %s done, %0d errors", name, errors - err0);
    endtask

    initial begin
        int fns [5];
        mips_pkg::word_t base;
        fns = '{`FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_SLT};
        seed = 32'h53a2_4de3;
        rst_n = 1'b0;
        dbg_ra = '0;
        errors = 0;
        checks = 0;
        tests = 0;
        timed_out = 1'b0;

        reset_dut();
        tests++;
        $display("test reset      done, %0d errors", errors);

        // Dependent chain over all ALU operations
        start_program();
        prog.push_back(i_type(`OP_ADDI, 1, 0, $random(seed)));
        for (int k = 0; k < 5; k++)
            prog.push_back(r_type(fns[k], k + 2, k + 1, 1));
        for (int k = 0; k < 12; k++)
            prog.push_back(r_type(fns[rnd(5)], 1 + rnd(15), 1 + rnd(15), 1 + rnd(15)));
        if (!timed_out) run_test("forwarding");

        // Load then immediate use
        start_program();
        prog.push_back(i_type(`OP_LW, 9, 0, 8));
        prog.push_back(r_type(`FN_ADD, 10, 9, 9));
        prog.push_back(i_type(`OP_LW, 11, 0, 12));
        prog.push_back(r_type(`FN_SUB, 12, 1, 11));
        prog.push_back(i_type(`OP_LW, 13, 0, 16));
        prog.push_back(i_type(`OP_SW, 13, 0, 20));
        prog.push_back(i_type(`OP_LW, 14, 0, 20));
        prog.push_back(i_type(`OP_ADDI, 15, 14, $random(seed)));
        if (!timed_out) run_test("load_use");

        // Stores, data straight from the previous result
        start_program();
        for (int k = 0; k < 8; k++) begin
            base = 1 + rnd(15);
            prog.push_back(i_type(`OP_ADDI, base, 1 + rnd(15), $random(seed)));
            prog.push_back(i_type(`OP_SW, base, 0, rnd(64) * 4));
            prog.push_back(i_type(`OP_SW, 1 + rnd(31), 0, rnd(64) * 4));
        end
        if (!timed_out) run_test("stores");

        // Taken BEQ, not-taken BEQ and J with markers
        start_program();
        prog.push_back(i_type(`OP_ADDI, 1, 0, 7));
        prog.push_back(i_type(`OP_ADDI, 2, 0, 7));
        prog.push_back(i_type(`OP_ADDI, 3, 0, 8));
        prog.push_back('0);
        prog.push_back('0);
        prog.push_back(i_type(`OP_BEQ, 2, 1, 3));
        prog.push_back(i_type(`OP_ADDI, 20, 0, $random(seed)));     // Slot
        prog.push_back(i_type(`OP_ADDI, 21, 0, $random(seed)));
        prog.push_back(i_type(`OP_ADDI, 22, 0, $random(seed)));
        prog.push_back(i_type(`OP_ADDI, 23, 0, $random(seed)));     // Target
        prog.push_back('0);
        prog.push_back('0);
        prog.push_back(i_type(`OP_BEQ, 3, 1, 2));
        prog.push_back(i_type(`OP_ADDI, 24, 0, $random(seed)));
        prog.push_back(i_type(`OP_ADDI, 25, 0, $random(seed)));     // Lost if BEQ taken
        prog.push_back(j_type(prog.size() * 4 + 12));
        prog.push_back(i_type(`OP_ADDI, 26, 0, $random(seed)));
        prog.push_back(i_type(`OP_ADDI, 27, 0, $random(seed)));
        prog.push_back(i_type(`OP_ADDI, 28, 0, $random(seed)));     // Jump lands here
        if (!timed_out) run_test("branch_jump");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end
endmodule

`default_nettype wire

/* vlog.f */
+incdir+src
src/mips_pkg.sv
src/pipe_ifs.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/mem_wb_stage.sv
src/hazard_unit.sv
src/mips_pipeline.sv
bench/tb_mem_models.sv
bench/mips_pipeline_tb.sv

/* Makefile */
# Verilator build and run of the MIPS pipeline testbench

VERILATOR ?= verilator
TOP       ?= mips_pipeline_tb
FLIST     ?= vlog.f
LOG       ?= sim.log
BUILD     ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD) $(LOG)
